/* logic/starforce_video_pkg.sv */
// widths, tile and pixel structs, layer count and default video timing constants
package starforce_video_pkg;

   // ============================================================
   // widths
   // ============================================================

   localparam int NUM_LAYERS = 3;

   // one row of one bit plane
   typedef logic [7:0] plane_t;
   typedef logic [2:0] color_t;
   // zero is transparent
   typedef logic [1:0] pix_t;
   // layer 0 is the foreground and wins
   typedef logic [1:0] layer_id_t;
   typedef logic [8:0] hcount_t;
   typedef logic [8:0] vcount_t;

   // ============================================================
   // tile and pixel records
   // ============================================================

   typedef struct packed {
      color_t color;
      plane_t plane1;
      plane_t plane0;
   } layer_tile_t;

   // layer[0] sits in the low bits
   typedef struct packed {
      layer_tile_t [NUM_LAYERS-1:0] layer;
   } tile_word_t;

   typedef struct packed {
      layer_id_t layer;
      color_t    color;
      pix_t      pix;
   } pixel_t;

   // ============================================================
   // default timing, about 6 MHz pixels from a 48 MHz clk
   // ============================================================

   localparam int DEF_PIX_DIV      = 8;
   localparam int DEF_H_ACTIVE     = 256;
   localparam int DEF_H_TOTAL      = 384;
   localparam int DEF_H_SYNC_START = 296;
   localparam int DEF_H_SYNC_LEN   = 32;
   localparam int DEF_V_ACTIVE     = 224;
   localparam int DEF_V_TOTAL      = 264;
   localparam int DEF_V_SYNC_START = 236;
   localparam int DEF_V_SYNC_LEN   = 3;
   localparam int DEF_FIFO_DEPTH   = 4;

endpackage

/* logic/video_timing.sv */
// pixel enable divider, horizontal and vertical counters, sync and blank, tile fetch strobe
module video_timing
   import starforce_video_pkg::*;
#(
   parameter int PIX_DIV      = DEF_PIX_DIV,
   parameter int H_ACTIVE     = DEF_H_ACTIVE,
   parameter int H_TOTAL      = DEF_H_TOTAL,
   parameter int H_SYNC_START = DEF_H_SYNC_START,
   parameter int H_SYNC_LEN   = DEF_H_SYNC_LEN,
   parameter int V_ACTIVE     = DEF_V_ACTIVE,
   parameter int V_TOTAL      = DEF_V_TOTAL,
   parameter int V_SYNC_START = DEF_V_SYNC_START,
   parameter int V_SYNC_LEN   = DEF_V_SYNC_LEN
)
(
   input  logic clk,
   input  logic CR,
   output logic pix_ce_o,
   output logic fetch_o,
   output logic hsync_o,
   output logic vsync_o,
   output logic hblank_o,
   output logic vblank_o
);

   localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   hcount_t          h_cnt;
   vcount_t          v_cnt;
   logic             h_last;
   logic             v_last;
   logic             group_end;
   logic             next_line_active;

   // ============================================================
   // pixel clock enable
   // ============================================================

   assign pix_ce_o = (div_cnt == DIV_W'(PIX_DIV - 1));

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         div_cnt <= '0;
      else if (pix_ce_o)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // ============================================================
   // raster counters, both advance on the pixel enable
   // ============================================================

   assign h_last = (h_cnt == H_TOTAL - 1);
   assign v_last = (v_cnt == V_TOTAL - 1);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         h_cnt <= '0;
         v_cnt <= '0;
      end
      else if (pix_ce_o)
      begin
         if (h_last)
         begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
         end
         else
         begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // sampled every clk, so they still describe the pixel just mixed
   // in the strobe clk after the enable (needs PIX_DIV of 2 or more)
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         hsync_o  <= 1'b0;
         vsync_o  <= 1'b0;
         hblank_o <= 1'b0;
         vblank_o <= 1'b0;
      end
      else
      begin
         hsync_o  <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + H_SYNC_LEN);
         vsync_o  <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + V_SYNC_LEN);
         hblank_o <= (h_cnt >= H_ACTIVE);
         vblank_o <= (v_cnt >= V_ACTIVE);
      end
   end

   // ============================================================
   // tile fetch, on the last pixel before each active group
   // ============================================================

   // in-line groups end at h = 7, 15 ... H_ACTIVE-9
   assign group_end = (h_cnt[2:0] == 3'd7) && (h_cnt < H_ACTIVE - 8) && (v_cnt < V_ACTIVE);

   // prefetch at end of line belongs to the next line
   assign next_line_active = v_last || (v_cnt < V_ACTIVE - 1);

   assign fetch_o = pix_ce_o && (h_last ? next_line_active : group_end);

   a_h_in_range : assert property (@(posedge clk) disable iff (!CR) h_cnt < H_TOTAL);

endmodule

/* logic/tile_fifo.sv */
// circular FIFO of tile words with a one clk credit pulse per popped word
module tile_fifo
   import starforce_video_pkg::*;
#(
   parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
   input  logic       clk,
   input  logic       CR,
   input  tile_word_t tile_i,
   input  logic       tile_valid_i,
   input  logic       pop_i,
   output tile_word_t tile_o,
   output logic       tile_ok_o,
   output logic       credit_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   tile_word_t       mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;

   // wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(FIFO_DEPTH));
   assign push  = tile_valid_i && !full;
   // a fetch on an empty FIFO is an underrun, nothing leaves
   assign pop   = pop_i && !empty;

   // word storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr] <= tile_i;
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         credit_o <= pop;
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head word goes straight to the shifters
   assign tile_o    = mem_q[rd_ptr];
   assign tile_ok_o = !empty;

   // source must spend a credit per word, so it never finds the FIFO full
   a_no_push_full : assert property (@(posedge clk) disable iff (!CR) tile_valid_i |-> !full);

endmodule

/* logic/plane_shifter.sv */
// two-plane load and shift register for one layer, shift direction set by flip
module plane_shifter
   import starforce_video_pkg::*;
(
   input  logic        clk,
   input  logic        CR,
   input  logic        pix_ce_i,
   input  logic        load_i,
   input  layer_tile_t tile_i,
   input  logic        tile_ok_i,
   input  logic        flip_i,
   output pix_t        pix_o,
   output color_t      color_o
);

   // mode as on the paired 4-bit shifters
   // 11 load, 01 shift left, 10 shift right, 00 hold
   logic [1:0]   mode;
   plane_t [1:0] plane_q;
   color_t       color_q;
   logic         flip_q;

   always_comb
   begin
      if (load_i)
         mode = 2'b11;
      else if (!pix_ce_i)
         mode = 2'b00;
      else if (flip_q)
         mode = 2'b10;
      else
         mode = 2'b01;
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         plane_q <= '0;
         flip_q  <= 1'b0;
      end
      else
      begin
         case (mode)
            2'b11:
            begin
               // underrun loads a transparent row
               plane_q[1] <= tile_ok_i ? tile_i.plane1 : '0;
               plane_q[0] <= tile_ok_i ? tile_i.plane0 : '0;
               flip_q     <= flip_i;
            end
            2'b01:
            begin
               plane_q[1] <= {plane_q[1][6:0], 1'b0};
               plane_q[0] <= {plane_q[0][6:0], 1'b0};
            end
            2'b10:
            begin
               plane_q[1] <= {1'b0, plane_q[1][7:1]};
               plane_q[0] <= {1'b0, plane_q[0][7:1]};
            end
            default:
            begin
               plane_q <= plane_q;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (load_i)
         color_q <= tile_ok_i ? tile_i.color : '0;
   end

   // exit end is bit 7, or bit 0 when flipped
   assign pix_o   = flip_q ? {plane_q[1][0], plane_q[0][0]} : {plane_q[1][7], plane_q[0][7]};
   assign color_o = color_q;

   // a load off the pixel enable would slip a row between two shifts
   a_load_on_ce : assert property (@(posedge clk) disable iff (!CR) load_i |-> pix_ce_i);

endmodule

/* logic/layer_priority.sv */
// priority mixer: first opaque layer wins, registered pixel and strobe, zero in blank
module layer_priority
   import starforce_video_pkg::*;
(
   input  logic                    clk,
   input  logic                    CR,
   input  logic                    pix_ce_i,
   input  logic                    blank_i,
   input  pix_t   [NUM_LAYERS-1:0] pix_i,
   input  color_t [NUM_LAYERS-1:0] color_i,
   output pixel_t                  pixel_o,
   output logic                    pixel_strobe_o
);

   pixel_t win;

   // walk from the back layer forward, lowest opaque index is left
   always_comb
   begin
      win = '0;
      for (int i = NUM_LAYERS - 1; i >= 0; i--)
      begin
         if (pix_i[i] != '0)
         begin
            win.layer = layer_id_t'(i);
            win.color = color_i[i];
            win.pix   = pix_i[i];
         end
      end
   end

   // ============================================================
   // output register
   // ============================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_o        <= '0;
         pixel_strobe_o <= 1'b0;
      end
      else
      begin
         pixel_strobe_o <= pix_ce_i;
         if (pix_ce_i)
            pixel_o <= blank_i ? '0 : win;
      end
   end

endmodule

/* logic/starforce_video_top.sv */
// video pixel path top level: raster timing, tile FIFO, layer shifters, priority mixer
module starforce_video_top
   import starforce_video_pkg::*;
#(
   parameter int PIX_DIV      = DEF_PIX_DIV,
   parameter int H_ACTIVE     = DEF_H_ACTIVE,
   parameter int H_TOTAL      = DEF_H_TOTAL,
   parameter int H_SYNC_START = DEF_H_SYNC_START,
   parameter int H_SYNC_LEN   = DEF_H_SYNC_LEN,
   parameter int V_ACTIVE     = DEF_V_ACTIVE,
   parameter int V_TOTAL      = DEF_V_TOTAL,
   parameter int V_SYNC_START = DEF_V_SYNC_START,
   parameter int V_SYNC_LEN   = DEF_V_SYNC_LEN,
   parameter int FIFO_DEPTH   = DEF_FIFO_DEPTH
)
(
   input  logic       clk,
   input  logic       CR,
   input  tile_word_t tile_i,
   input  logic       tile_valid_i,
   input  logic       flip_i,
   output logic       credit_o,
   output pixel_t     pixel_o,
   output logic       pixel_strobe_o,
   output logic       hsync_o,
   output logic       vsync_o,
   output logic       hblank_o,
   output logic       vblank_o
);

   logic                    pix_ce;
   logic                    fetch;
   tile_word_t              head_tile;
   logic                    head_ok;
   pix_t   [NUM_LAYERS-1:0] layer_pix;
   color_t [NUM_LAYERS-1:0] layer_color;

   // ============================================================
   // raster timing
   // ============================================================

   video_timing #(
      .PIX_DIV      (PIX_DIV),
      .H_ACTIVE     (H_ACTIVE),
      .H_TOTAL      (H_TOTAL),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_LEN   (H_SYNC_LEN),
      .V_ACTIVE     (V_ACTIVE),
      .V_TOTAL      (V_TOTAL),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_LEN   (V_SYNC_LEN)
   ) video_timing_i (
      .clk      (clk),
      .CR       (CR),
      .pix_ce_o (pix_ce),
      .fetch_o  (fetch),
      .hsync_o  (hsync_o),
      .vsync_o  (vsync_o),
      .hblank_o (hblank_o),
      .vblank_o (vblank_o)
   );

   // tile words in, one credit back per word taken by a fetch
   tile_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) tile_fifo_i (
      .clk          (clk),
      .CR           (CR),
      .tile_i       (tile_i),
      .tile_valid_i (tile_valid_i),
      .pop_i        (fetch),
      .tile_o       (head_tile),
      .tile_ok_o    (head_ok),
      .credit_o     (credit_o)
   );

   // ============================================================
   // one shifter pair per layer
   // ============================================================

   for (genvar i = 0; i < NUM_LAYERS; i++)
   begin : g_layer
      plane_shifter plane_shifter_i (
         .clk       (clk),
         .CR        (CR),
         .pix_ce_i  (pix_ce),
         .load_i    (fetch),
         .tile_i    (head_tile.layer[i]),
         .tile_ok_i (head_ok),
         .flip_i    (flip_i),
         .pix_o     (layer_pix[i]),
         .color_o   (layer_color[i])
      );
   end

   layer_priority layer_priority_i (
      .clk            (clk),
      .CR             (CR),
      .pix_ce_i       (pix_ce),
      .blank_i        (hblank_o | vblank_o),
      .pix_i          (layer_pix),
      .color_i        (layer_color),
      .pixel_o        (pixel_o),
      .pixel_strobe_o (pixel_strobe_o)
   );

endmodule

/* testbench/tb_video_model.svh */
// expected pixel by layer priority, fetch point decode and value check
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

// lowest numbered opaque layer wins
// column 0 is the first pixel out of the group
function automatic pixel_t expect_pixel(input tile_word_t w, input logic flip, input int col);
   pixel_t p;
   pix_t   px;
   int     idx;
   logic   found;
   p = '0;
   found = 1'b0;
   idx = flip ? col : 7 - col;
   for (int i = 0; i < NUM_LAYERS; i++)
   begin
      px = {w.layer[i].plane1[idx], w.layer[i].plane0[idx]};
      if (!found && px != 2'b00)
      begin
         p.layer = layer_id_t'(i);
         p.color = w.layer[i].color;
         p.pix   = px;
         found   = 1'b1;
      end
   end
   return p;
endfunction

// last pixel before an active group starts
// the prefetch for group 0 sits at the end of the line before
function automatic logic is_fetch_pixel(input int h, input int v);
   int next_v;
   next_v = (v + 1) % V_TOTAL;
   if (h == H_TOTAL - 1)
      return next_v < V_ACTIVE;
   return (v < V_ACTIVE) && ((h + 1) % 8 == 0) && (h + 1 < H_ACTIVE);
endfunction

task automatic check_value(input int test, input int got, input int exp, input string what);
   checks[test]++;
   if (got != exp)
   begin
      errors[test]++;
      $display("** Error @ %0t: %s at h=%0d v=%0d, got %0h, expected %0h",
               $time, what, h_exp, v_exp, got, exp);
   end
endtask

`endif

/* testbench/tb_starforce_video.sv */
// clock, reset, file driven tile feed with credits, model checks and summary
module tb_starforce_video
   import starforce_video_pkg::*;
();

   localparam int PIX_DIV      = DEF_PIX_DIV;
   localparam int H_ACTIVE     = DEF_H_ACTIVE;
   localparam int H_TOTAL      = DEF_H_TOTAL;
   localparam int H_SYNC_START = DEF_H_SYNC_START;
   localparam int H_SYNC_LEN   = DEF_H_SYNC_LEN;
   localparam int V_ACTIVE     = DEF_V_ACTIVE;
   localparam int V_TOTAL      = DEF_V_TOTAL;
   localparam int V_SYNC_START = DEF_V_SYNC_START;
   localparam int V_SYNC_LEN   = DEF_V_SYNC_LEN;
   localparam int FIFO_DEPTH   = DEF_FIFO_DEPTH;
   localparam int NUM_WORDS    = 12;
   // feed is withheld on this line to force underruns
   localparam int HOLD_LINE    = 3;

   logic clk;
   logic CR;
   tile_word_t tile_i;
   logic tile_valid_i;
   logic flip_i;
   logic credit_o;
   pixel_t pixel_o;
   logic pixel_strobe_o;
   logic hsync_o;
   logic vsync_o;
   logic hblank_o;
   logic vblank_o;

   logic [63:0] stim_mem [0:NUM_WORDS-1];
   logic [57:0] fifo_q [$];
   tile_word_t cur_word = '0;
   logic cur_flip = 1'b0;
   logic cur_under = 1'b0;
   logic send_flip = 1'b0;
   logic last_push = 1'b0;
   int credits = FIFO_DEPTH;
   int word_idx = 0;
   int h_exp = 0;
   int v_exp = 0;
   int lines_done = 0;
   int line_credits = 0;
   int line_pops = 0;
   int under_groups = 0;
   int checks [1:6] = '{default: 0};
   int errors [1:6] = '{default: 0};

   `include "tb_video_model.svh"

   starforce_video_top #(
      .PIX_DIV      (PIX_DIV),
      .H_ACTIVE     (H_ACTIVE),
      .H_TOTAL      (H_TOTAL),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_LEN   (H_SYNC_LEN),
      .V_ACTIVE     (V_ACTIVE),
      .V_TOTAL      (V_TOTAL),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_LEN   (V_SYNC_LEN),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) starforce_video_top_i (
      .clk            (clk),
      .CR             (CR),
      .tile_i         (tile_i),
      .tile_valid_i   (tile_valid_i),
      .flip_i         (flip_i),
      .credit_o       (credit_o),
      .pixel_o        (pixel_o),
      .pixel_strobe_o (pixel_strobe_o),
      .hsync_o        (hsync_o),
      .vsync_o        (vsync_o),
      .hblank_o       (hblank_o),
      .vblank_o       (vblank_o)
   );

   always #5 clk = ~clk;

   // ============================================================
   // tile source sending one word per held credit
   // ============================================================

   always @(posedge clk)
   begin
      logic [63:0] entry;
      if (CR)
      begin
         last_push = tile_valid_i;
         if (tile_valid_i)
            fifo_q.push_back({send_flip, tile_i});
         if (credits > 0 && v_exp != HOLD_LINE)
         begin
            entry = stim_mem[word_idx % NUM_WORDS];
            tile_i       <= entry[56:0];
            send_flip     = entry[60];
            tile_valid_i <= 1'b1;
            credits--;
            word_idx++;
         end
         else
            tile_valid_i <= 1'b0;
         // flip follows the FIFO head word
         flip_i <= (fifo_q.size() > 0) ? fifo_q[0][57] : 1'b0;
      end
   end

   // ============================================================
   // sampling in the middle of each clk
   // ============================================================

   task automatic sample_pixel();
      pixel_t exp_pix;
      int     avail;
      logic   fetch_now;
      int     test;
      check_value(5, int'(hsync_o),
                  int'(h_exp >= H_SYNC_START && h_exp < H_SYNC_START + H_SYNC_LEN), "hsync_o");
      check_value(5, int'(hblank_o), int'(h_exp >= H_ACTIVE), "hblank_o");
      check_value(5, int'(vsync_o),
                  int'(v_exp >= V_SYNC_START && v_exp < V_SYNC_START + V_SYNC_LEN), "vsync_o");
      check_value(5, int'(vblank_o), int'(v_exp >= V_ACTIVE), "vblank_o");
      if (h_exp < H_ACTIVE && v_exp < V_ACTIVE)
      begin
         exp_pix = expect_pixel(cur_word, cur_flip, h_exp % 8);
         test = cur_under ? 6 : (cur_flip ? 4 : 3);
         check_value(test, int'(pixel_o), int'(exp_pix), "pixel_o");
      end
      else
         check_value(3, int'(pixel_o), 0, "blank pixel_o");
      fetch_now = is_fetch_pixel(h_exp, v_exp);
      // a word pushed on the fetch edge was not yet in the FIFO
      avail = fifo_q.size() - int'(last_push);
      check_value(fetch_now && avail <= 0 ? 6 : 2, int'(credit_o),
                  int'(fetch_now && avail > 0), "credit_o");
      if (fetch_now && avail > 0)
      begin
         {cur_flip, cur_word} = fifo_q.pop_front();
         cur_under = 1'b0;
         line_pops++;
      end
      else if (fetch_now)
      begin
         cur_word  = '0;
         cur_flip  = 1'b0;
         cur_under = 1'b1;
         under_groups++;
      end
      if (h_exp == H_ACTIVE)
      begin
         if (v_exp < V_ACTIVE && line_pops == H_ACTIVE / 8)
            check_value(2, line_credits, H_ACTIVE / 8, "credits per line");
         line_credits = 0;
         line_pops = 0;
      end
      h_exp = (h_exp == H_TOTAL - 1) ? 0 : h_exp + 1;
      if (h_exp == 0)
      begin
         v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;
         lines_done++;
      end
   endtask

   always @(negedge clk)
   begin
      if (CR)
      begin
         if (credit_o)
         begin
            credits++;
            line_credits++;
         end
         checks[2]++;
         if (credits < 0 || credits > FIFO_DEPTH)
         begin
            errors[2]++;
            $display("** Error @ %0t: credits held out of range, %0d", $time, credits);
         end
         if (pixel_strobe_o)
            sample_pixel();
      end
   end

   // ============================================================
   // main sequence
   // ============================================================

   initial
   begin
      string names [1:6];
      int    cnt;
      int    total_checks;
      int    total_errors;
      logic  timed_out;
      names = '{"reset state", "credit rule", "pixels unflipped", "pixels flipped",
                "sync and blank", "underrun"};
      timed_out = 1'b0;
      clk = 1'b0;
      CR = 1'b0;
      tile_i = '0;
      tile_valid_i = 1'b0;
      flip_i = 1'b0;
      $readmemh("testbench/starforce_video_input.hex", stim_mem);
      repeat (16) @(posedge clk);
      CR <= 1'b1;

      // outputs stay quiet up to the first strobe
      cnt = 0;
      while (!pixel_strobe_o && cnt < 64)
      begin
         @(negedge clk);
         if (!pixel_strobe_o)
         begin
            check_value(1, int'({credit_o, hsync_o, vsync_o}), 0, "outputs after reset");
         end
         cnt++;
      end
      if (!pixel_strobe_o)
      begin
         timed_out = 1'b1;
         $display("timeout: no pixel strobe after reset");
      end
      $display("test 1 %s: %s", names[1], errors[1] == 0 ? "ok" : "failed");

      // one full frame and a few lines
      cnt = 0;
      while (!timed_out && lines_done < V_TOTAL + 2 && cnt < (V_TOTAL + 4) * H_TOTAL * PIX_DIV)
      begin
         @(posedge clk);
         cnt++;
      end
      if (!timed_out && lines_done < V_TOTAL + 2)
      begin
         timed_out = 1'b1;
         $display("timeout: frame did not complete");
      end
      if (checks[4] == 0)
      begin
         errors[4]++;
         $display("no flipped group was checked");
      end
      if (under_groups == 0)
      begin
         errors[6]++;
         $display("no underrun group was seen");
      end

      total_checks = 0;
      total_errors = 0;
      for (int t = 2; t <= 6; t++)
         $display("test %0d %s: %s (%0d checks, %0d errors)", t, names[t],
                  errors[t] == 0 ? "ok" : "failed", checks[t], errors[t]);
      for (int t = 1; t <= 6; t++)
      begin
         total_checks += checks[t];
         total_errors += errors[t];
      end
      $display("summary: %0d checks, %0d errors, %0d underrun groups",
               total_checks, total_errors, under_groups);
      if (timed_out || total_errors != 0)
         $display(">>> FAIL");
      else
         $display(">>> PASS");
      $finish;
   end

endmodule

/* testbench/starforce_video_input.hex */
// columns: flip in bit 60, tile word in bits 56:0
// tile word: layer 2 bits 56:38, layer 1 bits 37:19, layer 0 bits 18:0 (color, plane1, plane0)
00a5c3f0e1d2b487
0123456789abcdef
1000000005f0f000
01fffe0000000000
0000ff00000700ff
1155aa33cc0f81e7
00deadbeefca1135
10000c3c0e781ff0
0072640000000000
1048ff1200480081
0000000000000000
013579bdf2468ace

/* starforce_video.f */
logic/starforce_video_pkg.sv
logic/video_timing.sv
logic/tile_fifo.sv
logic/plane_shifter.sv
logic/layer_priority.sv
logic/starforce_video_top.sv
+incdir+testbench
testbench/tb_starforce_video.sv

/* Makefile */
TOP = tb_starforce_video

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f starforce_video.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -qx '>>> PASS' sim.log

lint:
	verilator --lint-only -Wall --top-module starforce_video_top \
		logic/starforce_video_pkg.sv logic/video_timing.sv logic/tile_fifo.sv \
		logic/plane_shifter.sv logic/layer_priority.sv logic/starforce_video_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
